/* include/cobs_defs.svh */
// COBS encoder constants
// byte width, FIFO depth and the code values used by the encoder

`ifndef COBS_DEFS_SVH
`define COBS_DEFS_SVH

// width of one stream byte
`define COBS_BYTE_W 8

// entries in each of the code and data FIFOs
`define COBS_FIFO_DEPTH 256

// code for a full run of 254 nonzero bytes
`define COBS_MAX_CODE (`COBS_BYTE_W'(255))
// code for an empty run
`define COBS_ZERO_CODE (`COBS_BYTE_W'(1))
// frame delimiter appended after every encoded frame
`define COBS_FRAME_END (`COBS_BYTE_W'(0))

`endif

/* source/cobs_pkg.sv */
// COBS encoder types
// byte and stream beat shared by the pipeline stages

`default_nettype none

`include "cobs_defs.svh"

package cobs_pkg;

    // one byte of the stream
    typedef logic [`COBS_BYTE_W-1:0] cobs_byte_t;

    // stream payload, also the code FIFO entry
    typedef struct packed {
        cobs_byte_t data;
        logic       last;
    } cobs_beat_t;

endpackage

`default_nettype wire

/* source/cobs_fifo.sv */
// Synchronous FIFO with first-word fall-through read
// holds either code beats or data bytes between the two encoder halves

`timescale 1ns/1ps
`default_nettype none

`include "cobs_defs.svh"

module cobs_fifo #(
    parameter int width = 8
) (
    input  wire logic             clk,
    input  wire logic             rst,

    input  wire logic [width-1:0] in_data,
    input  wire logic             in_valid,
    output logic                  in_ready,

    output logic      [width-1:0] out_data,
    output logic                  out_valid,
    input  wire logic             out_ready
);

    localparam int addr_w = $clog2(`COBS_FIFO_DEPTH);

    logic [width-1:0] mem [`COBS_FIFO_DEPTH];

    // extra msb tells a full buffer from an empty one
    logic [addr_w:0] wr_ptr;
    logic [addr_w:0] rd_ptr;
    logic            full;
    logic            empty;

    assign full  = (wr_ptr == {~rd_ptr[addr_w], rd_ptr[addr_w-1:0]});
    assign empty = (wr_ptr == rd_ptr);

    assign in_ready  = !full;
    assign out_valid = !empty;
    assign out_data  = mem[rd_ptr[addr_w-1:0]];

    always_ff @(posedge clk) begin
        if (in_valid && !full) begin
            mem[wr_ptr[addr_w-1:0]] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (in_valid && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (out_ready && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/cobs_segmenter.sv */
// COBS input stage
// counts runs of nonzero bytes, writes data bytes and their codes to two FIFOs

`timescale 1ns/1ps
`default_nettype none

`include "cobs_defs.svh"

module cobs_segmenter (
    input  wire logic               clk,
    input  wire logic               rst,

    input  wire cobs_pkg::cobs_beat_t s_beat,
    input  wire logic               s_valid,
    output logic                    s_ready,

    output cobs_pkg::cobs_beat_t    code_in_beat,
    output logic                    code_in_valid,
    input  wire logic               code_in_ready,

    output cobs_pkg::cobs_byte_t    data_in_byte,
    output logic                    data_in_valid,
    input  wire logic               data_in_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_segment,
        st_final_empty,
        st_frame_end
    } state_t;

    state_t               state_reg;
    state_t               state_next;
    cobs_pkg::cobs_byte_t count_reg;
    cobs_pkg::cobs_byte_t count_next;
    logic                 accepting;
    logic                 take;

    // both FIFOs must have room, so a beat is never split across cycles
    assign accepting = (state_reg == st_idle) || (state_reg == st_segment);
    assign s_ready   = accepting && code_in_ready && data_in_ready;
    assign take      = s_valid && s_ready;

    // zero bytes are dropped through data_in_valid
    assign data_in_byte = s_beat.data;

    always_comb begin
        state_next         = state_reg;
        count_next         = count_reg;
        code_in_beat.data  = `COBS_ZERO_CODE;
        code_in_beat.last  = 1'b0;
        code_in_valid      = 1'b0;
        data_in_valid      = 1'b0;

        case (state_reg)
            st_idle: begin
                if (take) begin
                    if (s_beat.data == `COBS_FRAME_END) begin
                        // zero with no run before it
                        code_in_beat.data = `COBS_ZERO_CODE;
                        code_in_valid     = 1'b1;
                        if (s_beat.last) begin
                            state_next = st_final_empty;
                        end
                    end else begin
                        data_in_valid = 1'b1;
                        count_next    = `COBS_BYTE_W'(2);
                        if (s_beat.last) begin
                            code_in_beat.data = `COBS_BYTE_W'(2);
                            code_in_valid     = 1'b1;
                            state_next        = st_frame_end;
                        end else begin
                            state_next = st_segment;
                        end
                    end
                end
            end
            st_segment: begin
                if (take) begin
                    if (s_beat.data == `COBS_FRAME_END) begin
                        // zero closes the run
                        code_in_beat.data = count_reg;
                        code_in_valid     = 1'b1;
                        state_next        = s_beat.last ? st_final_empty : st_idle;
                    end else begin
                        data_in_valid = 1'b1;
                        count_next    = count_reg + 1'b1;
                        // split the run once it holds 254 bytes
                        if (count_reg == `COBS_MAX_CODE - 1'b1) begin
                            code_in_beat.data = `COBS_MAX_CODE;
                            code_in_valid     = 1'b1;
                            count_next        = `COBS_ZERO_CODE;
                        end
                        if (s_beat.last) begin
                            code_in_beat.data = count_reg + 1'b1;
                            code_in_valid     = 1'b1;
                            state_next        = st_frame_end;
                        end
                    end
                end
            end
            st_final_empty: begin
                // frame ended on a zero so one more empty run follows
                code_in_beat.data = `COBS_ZERO_CODE;
                code_in_valid     = 1'b1;
                if (code_in_ready) begin
                    state_next = st_frame_end;
                end
            end
            st_frame_end: begin
                code_in_beat.data = `COBS_FRAME_END;
                code_in_beat.last = 1'b1;
                code_in_valid     = 1'b1;
                if (code_in_ready) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= st_idle;
        end else begin
            state_reg <= state_next;
        end
        count_reg <= count_next;
    end

endmodule

`default_nettype wire

/* source/cobs_merger.sv */
// COBS output stage
// sends each code byte, then the run of data bytes that belongs to it

`timescale 1ns/1ps
`default_nettype none

`include "cobs_defs.svh"

module cobs_merger (
    input  wire logic                 clk,
    input  wire logic                 rst,

    input  wire cobs_pkg::cobs_beat_t code_out_beat,
    input  wire logic                 code_out_valid,
    output logic                      code_out_ready,

    input  wire cobs_pkg::cobs_byte_t data_out_byte,
    input  wire logic                 data_out_valid,
    output logic                      data_out_ready,

    output cobs_pkg::cobs_beat_t      int_beat,
    output logic                      int_valid,
    input  wire logic                 int_ready
);

    typedef enum logic {
        st_code,
        st_data
    } state_t;

    state_t               state_reg;
    state_t               state_next;
    cobs_pkg::cobs_byte_t count_reg;
    cobs_pkg::cobs_byte_t count_next;

    always_comb begin
        state_next     = state_reg;
        count_next     = count_reg;
        int_beat       = code_out_beat;
        int_valid      = 1'b0;
        code_out_ready = 1'b0;
        data_out_ready = 1'b0;

        case (state_reg)
            st_code: begin
                if (int_ready && code_out_valid) begin
                    int_valid      = 1'b1;
                    code_out_ready = 1'b1;
                    count_next     = code_out_beat.data - 1'b1;
                    // delimiter and empty-run codes carry no data
                    if (code_out_beat.data != `COBS_FRAME_END &&
                        code_out_beat.data != `COBS_ZERO_CODE) begin
                        state_next = st_data;
                    end
                end
            end
            st_data: begin
                int_beat.data = data_out_byte;
                int_beat.last = 1'b0;
                if (int_ready && data_out_valid) begin
                    int_valid      = 1'b1;
                    data_out_ready = 1'b1;
                    count_next     = count_reg - 1'b1;
                    if (count_reg == `COBS_BYTE_W'(1)) begin
                        state_next = st_code;
                    end
                end
            end
            default: begin
                state_next = st_code;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= st_code;
        end else begin
            state_reg <= state_next;
        end
        count_reg <= count_next;
    end

endmodule

`default_nettype wire

/* source/cobs_skid_buffer.sv */
// Output register stage with one spare slot
// keeps the upstream ready registered so it does not depend on m_ready

`timescale 1ns/1ps
`default_nettype none

module cobs_skid_buffer (
    input  wire logic                 clk,
    input  wire logic                 rst,

    input  wire cobs_pkg::cobs_beat_t int_beat,
    input  wire logic                 int_valid,
    output logic                      int_ready,

    output cobs_pkg::cobs_beat_t      m_beat,
    output logic                      m_valid,
    input  wire logic                 m_ready
);

    cobs_pkg::cobs_beat_t out_beat_reg;
    cobs_pkg::cobs_beat_t temp_beat_reg;
    logic                 temp_valid_reg;
    logic                 int_ready_early;
    logic                 to_output;
    logic                 to_temp;
    logic                 temp_to_output;

    assign m_beat = out_beat_reg;

    // accept next cycle unless the temp slot could fill up
    assign int_ready_early = m_ready || (!temp_valid_reg && (!m_valid || !int_valid));

    always_comb begin
        to_output      = 1'b0;
        to_temp        = 1'b0;
        temp_to_output = 1'b0;
        if (int_ready) begin
            if (m_ready || !m_valid) begin
                to_output = 1'b1;
            end else begin
                to_temp = 1'b1;
            end
        end else if (m_ready) begin
            temp_to_output = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid        <= 1'b0;
            temp_valid_reg <= 1'b0;
            int_ready      <= 1'b0;
        end else begin
            int_ready <= int_ready_early;
            if (to_output) begin
                m_valid <= int_valid;
            end else if (to_temp) begin
                temp_valid_reg <= int_valid;
            end else if (temp_to_output) begin
                m_valid        <= temp_valid_reg;
                temp_valid_reg <= 1'b0;
            end
        end
        if (to_output) begin
            out_beat_reg <= int_beat;
        end else if (temp_to_output) begin
            out_beat_reg <= temp_beat_reg;
        end
        if (to_temp) begin
            temp_beat_reg <= int_beat;
        end
    end

endmodule

`default_nettype wire

/* source/cobs_encode.sv */
// COBS encoder top level
// segmenter, code and data FIFOs, merger and output skid buffer in a row

`timescale 1ns/1ps
`default_nettype none

`include "cobs_defs.svh"

module cobs_encode (
    input  wire logic                 clk,
    input  wire logic                 rst,

    input  wire cobs_pkg::cobs_beat_t s_beat,
    input  wire logic                 s_valid,
    output logic                      s_ready,

    output cobs_pkg::cobs_beat_t      m_beat,
    output logic                      m_valid,
    input  wire logic                 m_ready
);

    cobs_pkg::cobs_beat_t code_in_beat;
    logic                 code_in_valid;
    logic                 code_in_ready;
    cobs_pkg::cobs_byte_t data_in_byte;
    logic                 data_in_valid;
    logic                 data_in_ready;

    cobs_pkg::cobs_beat_t code_out_beat;
    logic                 code_out_valid;
    logic                 code_out_ready;
    cobs_pkg::cobs_byte_t data_out_byte;
    logic                 data_out_valid;
    logic                 data_out_ready;

    cobs_pkg::cobs_beat_t int_beat;
    logic                 int_valid;
    logic                 int_ready;

    cobs_segmenter u_segmenter (
        .clk(clk), .rst(rst),
        .s_beat(s_beat), .s_valid(s_valid), .s_ready(s_ready),
        .code_in_beat(code_in_beat), .code_in_valid(code_in_valid),
        .code_in_ready(code_in_ready),
        .data_in_byte(data_in_byte), .data_in_valid(data_in_valid),
        .data_in_ready(data_in_ready)
    );

    // code beats keep last, which marks the frame delimiter
    cobs_fifo #(.width($bits(cobs_pkg::cobs_beat_t))) u_code_fifo (
        .clk(clk), .rst(rst),
        .in_data(code_in_beat), .in_valid(code_in_valid), .in_ready(code_in_ready),
        .out_data(code_out_beat), .out_valid(code_out_valid), .out_ready(code_out_ready)
    );

    cobs_fifo #(.width(`COBS_BYTE_W)) u_data_fifo (
        .clk(clk), .rst(rst),
        .in_data(data_in_byte), .in_valid(data_in_valid), .in_ready(data_in_ready),
        .out_data(data_out_byte), .out_valid(data_out_valid), .out_ready(data_out_ready)
    );

    cobs_merger u_merger (
        .clk(clk), .rst(rst),
        .code_out_beat(code_out_beat), .code_out_valid(code_out_valid),
        .code_out_ready(code_out_ready),
        .data_out_byte(data_out_byte), .data_out_valid(data_out_valid),
        .data_out_ready(data_out_ready),
        .int_beat(int_beat), .int_valid(int_valid), .int_ready(int_ready)
    );

    cobs_skid_buffer u_skid_buffer (
        .clk(clk), .rst(rst),
        .int_beat(int_beat), .int_valid(int_valid), .int_ready(int_ready),
        .m_beat(m_beat), .m_valid(m_valid), .m_ready(m_ready)
    );

endmodule

`default_nettype wire

/* verif/cobs_encode_tb.sv */
// COBS encoder testbench
// drives directed and random frames and compares every output beat with a reference encoder

`timescale 1ns/1ps
`default_nettype none

`include "cobs_defs.svh"

module cobs_encode_tb;

    typedef cobs_pkg::cobs_byte_t byte_q_t[$];
    typedef cobs_pkg::cobs_beat_t beat_q_t[$];

    localparam int num_directed = 9;
    localparam int num_random   = 24;
    localparam int max_run      = 254;

    logic                 clk;
    logic                 rst;
    cobs_pkg::cobs_beat_t s_beat;
    logic                 s_valid;
    logic                 s_ready;
    cobs_pkg::cobs_beat_t m_beat;
    logic                 m_valid;
    logic                 m_ready;

    // frames stored back to back with one length and one name per frame
    cobs_pkg::cobs_byte_t stim_q[$];
    int                   len_q[$];
    string                name_q[$];

    // expected beats of the frames sent so far
    cobs_pkg::cobs_beat_t exp_q[$];
    string                pending_q[$];
    int                   frame_errs;
    int                   pass_count;
    int                   fail_count;
    int                   stray_count;
    int                   frames_seen;
    logic                 random_phase;
    int                   cycle_count;
    int                   cycle_limit;

    cobs_encode u_cobs_encode (
        .clk(clk), .rst(rst),
        .s_beat(s_beat), .s_valid(s_valid), .s_ready(s_ready),
        .m_beat(m_beat), .m_valid(m_valid), .m_ready(m_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic cobs_pkg::cobs_beat_t make_beat(input cobs_pkg::cobs_byte_t data,
                                                       input logic last);
        cobs_pkg::cobs_beat_t b;
        b.data = data;
        b.last = last;
        return b;
    endfunction

    // each code is the length of the following nonzero run plus one
    function automatic beat_q_t cobs_ref_encode(input byte_q_t frame);
        beat_q_t out;
        byte_q_t run;
        logic    open;
        open = 1'b1;
        for (int i = 0; i < frame.size(); i++) begin
            if (frame[i] == 8'h00) begin
                out.push_back(make_beat(cobs_pkg::cobs_byte_t'(run.size() + 1), 1'b0));
                foreach (run[j]) begin
                    out.push_back(make_beat(run[j], 1'b0));
                end
                run.delete();
                open = 1'b1;
            end else begin
                run.push_back(frame[i]);
                if (run.size() == max_run) begin
                    out.push_back(make_beat(`COBS_MAX_CODE, 1'b0));
                    foreach (run[j]) begin
                        out.push_back(make_beat(run[j], 1'b0));
                    end
                    run.delete();
                    // a new run only opens if the frame goes on
                    open = (i < frame.size() - 1);
                end
            end
        end
        if (frame[frame.size() - 1] == 8'h00) begin
            out.push_back(make_beat(8'h01, 1'b0));
        end else if (open) begin
            out.push_back(make_beat(cobs_pkg::cobs_byte_t'(run.size() + 1), 1'b0));
            foreach (run[j]) begin
                out.push_back(make_beat(run[j], 1'b0));
            end
        end
        out.push_back(make_beat(8'h00, 1'b1));
        return out;
    endfunction

    function automatic byte_q_t nonzero_run(input int n);
        byte_q_t q;
        for (int i = 0; i < n; i++) begin
            q.push_back(cobs_pkg::cobs_byte_t'((i % 255) + 1));
        end
        return q;
    endfunction

    task automatic add_frame(input string name, input byte_q_t frame);
        foreach (frame[i]) begin
            stim_q.push_back(frame[i]);
        end
        len_q.push_back(frame.size());
        name_q.push_back(name);
    endtask

    task automatic check_beat(input string name, input cobs_pkg::cobs_beat_t expected,
                              input cobs_pkg::cobs_beat_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected data %02h last %0b, got data %02h last %0b",
                     name, expected.data, expected.last, actual.data, actual.last);
            frame_errs++;
        end
    endtask

    task automatic check_idle(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %0b, got %0b", name, expected, actual);
            frame_errs++;
        end
    endtask

    task automatic report_test(input string name);
        if (frame_errs == 0) begin
            $display("test %s: ok", name);
            pass_count++;
        end else begin
            $display("test %s: %0d mismatches", name, frame_errs);
            fail_count++;
        end
        frame_errs = 0;
    endtask

    // called 2 ns after a rising edge and returns 2 ns after the edge that took the beat
    task automatic send_beat(input cobs_pkg::cobs_beat_t beat);
        logic accepted;
        accepted = 1'b0;
        while (random_phase && $urandom_range(3) == 0) begin
            s_valid = 1'b0;
            @(posedge clk);
            #2;
        end
        s_beat  = beat;
        s_valid = 1'b1;
        while (!accepted) begin
            @(negedge clk);
            accepted = s_ready;
            @(posedge clk);
            #2;
        end
        s_valid = 1'b0;
    endtask

    initial begin
        m_ready = 1'b1;
        forever begin
            @(posedge clk);
            #2;
            m_ready = random_phase ? ($urandom_range(3) != 0) : 1'b1;
        end
    end

    // output beats are sampled at the falling edge before the edge that transfers them
    always @(negedge clk) begin
        if (!rst && m_valid && m_ready) begin
            if (exp_q.size() == 0) begin
                $display("output beat %02h arrived with no frame pending", m_beat.data);
                stray_count++;
            end else begin
                check_beat(pending_q[0], exp_q[0], m_beat);
                if (exp_q[0].last) begin
                    report_test(pending_q[0]);
                    void'(pending_q.pop_front());
                    frames_seen++;
                end
                void'(exp_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("run stopped after %0d cycles with %0d frames still outstanding",
                     cycle_count, len_q.size() - frames_seen);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        int      base;
        int      len;
        byte_q_t frame;
        beat_q_t expected;
        void'($urandom(32'hd9a0_4158));
        rst          = 1'b1;
        s_beat       = '0;
        s_valid      = 1'b0;
        random_phase = 1'b0;
        frame_errs   = 0;
        pass_count   = 0;
        fail_count   = 0;
        stray_count  = 0;
        frames_seen  = 0;
        cycle_count  = 0;

        frame = '{8'h11, 8'h22, 8'h33, 8'h44, 8'h55};
        add_frame("nonzero_only", frame);
        frame = '{8'h00, 8'h01, 8'h02};
        add_frame("leading_zero", frame);
        frame = '{8'h01, 8'h02, 8'h00};
        add_frame("trailing_zero", frame);
        frame = '{8'h05, 8'h00, 8'h00, 8'h00, 8'h06};
        add_frame("consecutive_zeros", frame);
        frame = '{8'h00};
        add_frame("single_zero", frame);
        add_frame("run_254", nonzero_run(254));
        add_frame("run_255", nonzero_run(255));
        add_frame("run_600", nonzero_run(600));
        frame = nonzero_run(254);
        frame.push_back(8'h00);
        add_frame("run_254_then_zero", frame);

        for (int f = 0; f < num_random; f++) begin
            frame.delete();
            len = $urandom_range(300, 1);
            for (int i = 0; i < len; i++) begin
                // odd frames rarely see a zero, so their runs get split
                if ($urandom_range((f % 2) ? 511 : 3) == 0) begin
                    frame.push_back(8'h00);
                end else begin
                    frame.push_back(cobs_pkg::cobs_byte_t'($urandom_range(255, 1)));
                end
            end
            add_frame($sformatf("random_%0d", f), frame);
        end
        cycle_limit = stim_q.size() * 4 + 2000;

        repeat (8) begin
            @(posedge clk);
            #2;
            check_idle("m_valid in reset", 1'b0, m_valid);
        end
        rst = 1'b0;
        @(posedge clk);
        #2;
        check_idle("m_valid after reset", 1'b0, m_valid);
        check_idle("s_ready after reset", 1'b1, s_ready);
        report_test("reset");

        base = 0;
        foreach (len_q[f]) begin
            frame.delete();
            for (int i = 0; i < len_q[f]; i++) begin
                frame.push_back(stim_q[base + i]);
            end
            base += len_q[f];
            expected = cobs_ref_encode(frame);
            foreach (expected[i]) begin
                exp_q.push_back(expected[i]);
            end
            pending_q.push_back(name_q[f]);
            random_phase = (f >= num_directed);
            foreach (frame[i]) begin
                send_beat(make_beat(frame[i], i == frame.size() - 1));
            end
        end

        wait (frames_seen == len_q.size());
        random_phase = 1'b0;
        repeat (20) @(posedge clk);
        #2;
        check_idle("m_valid after last frame", 1'b0, m_valid);
        report_test("drain");

        $display("%0d tests passed, %0d tests with mismatches, %0d stray beats",
                 pass_count, fail_count, stray_count);
        if (fail_count == 0 && stray_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
source/cobs_pkg.sv
source/cobs_fifo.sv
source/cobs_segmenter.sv
source/cobs_merger.sv
source/cobs_skid_buffer.sv
source/cobs_encode.sv
verif/cobs_encode_tb.sv

/* Bender.yml */
package:
  name: cobs_encode

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/cobs_pkg.sv
      - source/cobs_fifo.sv
      - source/cobs_segmenter.sv
      - source/cobs_merger.sv
      - source/cobs_skid_buffer.sv
      - source/cobs_encode.sv

  - target: test
    include_dirs:
      - include
    files:
      - verif/cobs_encode_tb.sv
